//--- list.f
+incdir+.
fe_pkg.sv
pcGen.sv
excCtrl.sv
instrMem.sv
fetchReg.sv
frontendStage.sv
fe_assertions.sv
frontendTb.sv

//--- fe_testdata.txt
# L byteAddr word   : program load through the debug port
# S stall pcSel target excReq excRet | pc2 instr2 misaligned2 valid2 (seen one step later)
L 00000000 c0de0000
L 00000004 c0de0004
L 00000008 c0de0008
L 0000000c c0de000c
L 00000010 c0de0010
L 00000014 c0de0014
L 00000018 c0de0018
L 0000001c c0de001c
L 00000020 c0de0020
L 00000024 c0de0024
L 00000028 c0de0028
L 0000002c c0de002c
L 00000080 c0de0080
L 00000084 c0de0084
L 00000088 c0de0088
S 0 0 00000000 0 0 00000008 c0de0008 0 1
S 0 0 00000000 0 0 0000000c c0de000c 0 1
S 0 2 00000020 0 0 00000020 c0de0020 0 1
S 0 0 00000000 0 0 00000024 c0de0024 0 1
S 0 3 00000000 0 0 00000024 c0de0024 0 1
S 0 0 00000000 0 0 00000028 c0de0028 0 1
S 0 1 00000000 0 0 00000000 c0de0000 0 1
S 0 0 00000000 0 0 00000000 c0de0000 0 1
S 1 0 00000000 0 0 00000000 c0de0000 0 1
S 1 0 00000000 0 0 00000004 c0de0004 0 1
S 0 0 00000000 0 0 00000008 c0de0008 0 1
S 0 0 00000000 0 0 0000000c c0de000c 0 1
S 0 0 00000000 1 0 00000080 c0de0080 0 1
S 0 0 00000000 0 0 00000084 c0de0084 0 1
S 0 0 00000000 1 0 00000084 c0de0084 0 1
S 1 0 00000000 0 0 00000088 c0de0088 0 1
S 0 0 00000000 0 1 0000000c c0de000c 0 1
S 0 0 00000000 0 0 00000010 c0de0010 0 1
S 0 2 00000012 0 0 00000012 c0de0010 1 1
S 0 2 0000001c 0 0 0000001c c0de001c 0 1
S 0 0 00000000 0 0 00000020 c0de0020 0 1
S 0 0 00000000 0 0 00000020 c0de0020 0 1
S 1 0 00000000 1 0 00000080 c0de0080 0 1
S 0 0 00000000 0 0 00000084 c0de0084 0 1
S 0 0 00000000 0 1 00000024 c0de0024 0 1
S 0 0 00000000 0 0 00000028 c0de0028 0 1
S 0 0 00000000 0 0 0000002c c0de002c 0 1

//--- frontendTb.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module frontendTb import fe_pkg::*;
();

	logic                clk;
	logic                nrst;
	logic                stall;
	pcSel_e              pcSel;
	logic [`FE_XLEN-1:0] target;
	logic                excReq;
	logic                excRet;
	logic                dbgWe;
	logic [`FE_XLEN-1:0] dbgAddr;
	logic [`FE_XLEN-1:0] dbgData;
	logic [`FE_XLEN-1:0] pc2;
	logic [`FE_XLEN-1:0] instr2;
	logic                misaligned2;
	logic                valid2;
	logic [`FE_XLEN-1:0] savedPc;

	// records from the data file
	logic [31:0] ldAddr [$];
	logic [31:0] ldData [$];
	logic [31:0] stIn [$][5];  // stall, pcSel, target, excReq, excRet
	logic [31:0] stExp [$][4]; // pc2, instr2, misaligned2, valid2

	// reference model state
	logic [31:0] mMem [`FE_MEM_WORDS];
	logic [31:0] mF;
	logic [31:0] mSaved;
	logic [31:0] mPc2;
	logic [31:0] mInstr;
	logic        mMis;
	logic        mMis2;
	logic        mValid;
	logic        mAct;

	integer errors;
	integer checks;
	logic   timedOut;
	logic [31:0] rnd;

	frontendStage dut_i (.*);

	bind frontendStage fe_assertions feAssert_i (
		.clk(clk), .nrst(nrst), .stall(stall), .trapTake(trapTake),
		.pc2(pc2), .valid2(valid2)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic readData();
		integer fd;
		integer rc;
		string line;
		logic [31:0] f [9];
		fd = $fopen("fe_testdata.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open fe_testdata.txt");
			return;
		end
		while (!$feof(fd))
		begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) == "L")
			begin
				rc = $sscanf(line, "L %h %h", f[0], f[1]);
				ldAddr.push_back(f[0]);
				ldData.push_back(f[1]);
			end
			else if (rc > 0 && line.getc(0) == "S")
			begin
				rc = $sscanf(line, "S %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				stIn.push_back('{f[0], f[1], f[2], f[3], f[4]});
				stExp.push_back('{f[5], f[6], f[7], f[8]});
			end
		end
		$fclose(fd);
	endtask

	// one rising edge of the front end for the stimulus now driven
	task automatic modelClock();
		logic trap;
		logic ret;
		logic [31:0] nxt;
		trap = excReq && !mAct;
		ret  = excRet && mAct;
		if (trap) nxt = `FE_TRAP_VEC;
		else if (ret) nxt = mSaved;
		else if (stall) nxt = mF;
		else if (pcSel == PC_RESET) nxt = `FE_RESET_VEC;
		else if (pcSel == PC_TARGET) nxt = target;
		else if (pcSel == PC_HOLD) nxt = mF;
		else nxt = mF + 32'd4;
		if (!stall)
		begin
			mPc2   = mF;
			mInstr = mMem[mF[7:2]];
			mMis2  = mMis;
			mValid = 1'b1;
		end
		if (trap)
		begin
			mAct   = 1'b1;
			mSaved = mF; // interrupted fetch
		end
		else if (ret)
			mAct = 1'b0;
		mF   = nxt;
		mMis = |nxt[1:0];
	endtask

	task automatic checkOutputs(input logic [31:0] e [4]);
		compareValue("pc2", e[0], pc2);
		compareValue("instr2", e[1], instr2);
		compareValue("misaligned2", e[2], {31'd0, misaligned2});
		compareValue("valid2", e[3], {31'd0, valid2});
		compareValue("savedPc", mSaved, savedPc);
	endtask

	initial
	begin
		integer i;
		integer n;
		nrst = 1'b0;
		stall = 1'b0;
		pcSel = PC_SEQ;
		target = '0;
		excReq = 1'b0;
		excRet = 1'b0;
		dbgWe = 1'b0;
		dbgAddr = '0;
		dbgData = '0;
		errors = 0;
		checks = 0;
		timedOut = 1'b0;
		rnd = 32'd36;
		readData();
		// program load while held in reset
		@(negedge clk);
		for (i = 0; i < ldAddr.size(); i++)
		begin
			dbgWe   = 1'b1;
			dbgAddr = ldAddr[i];
			dbgData = ldData[i];
			mMem[ldAddr[i][7:2]] = ldData[i];
			@(negedge clk);
		end
		dbgWe = 1'b0;
		repeat (10) @(negedge clk);
		compareValue("valid2", 32'd0, {31'd0, valid2});
		nrst = 1'b1;
		mF = `FE_RESET_VEC;
		mMis = 1'b0;
		mValid = 1'b0;
		mAct = 1'b0;
		mSaved = '0;
		// wait for the first fetch
		n = 0;
		while (!valid2 && !timedOut)
		begin
			@(posedge clk);
			modelClock();
			@(negedge clk);
			n++;
			if (n > 8 && !valid2)
			begin
				timedOut = 1'b1;
				errors++;
				$display("valid2 never went high after reset");
			end
		end
		if (!timedOut)
		begin
			checkOutputs('{mPc2, mInstr, {31'd0, mMis2}, {31'd0, mValid}});
			// file steps whose expectations show one step later
			for (i = 0; i < stIn.size(); i++)
			begin
				stall  = stIn[i][0][0];
				pcSel  = pcSel_e'(stIn[i][1][1:0]);
				target = stIn[i][2];
				excReq = stIn[i][3][0];
				excRet = stIn[i][4][0];
				@(posedge clk);
				modelClock();
				@(negedge clk);
				if (i > 0)
					checkOutputs(stExp[i-1]);
				else
					checkOutputs('{mPc2, mInstr, {31'd0, mMis2}, {31'd0, mValid}}); // second fetch
			end
			// filler steps with random stalls and an unstalled first one
			for (i = 0; i < 24; i++)
			begin
				rnd = nextRandom(rnd);
				stall  = (i == 0) ? 1'b0 : rnd[3];
				pcSel  = (mF >= 32'h28) ? PC_RESET : PC_SEQ; // stay in loaded words
				target = '0;
				excReq = 1'b0;
				excRet = 1'b0;
				@(posedge clk);
				modelClock();
				@(negedge clk);
				if (i == 0) checkOutputs(stExp[stExp.size()-1]);
				else checkOutputs('{mPc2, mInstr, {31'd0, mMis2}, {31'd0, mValid}});
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- fe_assertions.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module fe_assertions
(
	input logic                clk,
	input logic                nrst,
	input logic                stall,
	input logic                trapTake, // internal, from excCtrl
	input logic [`FE_XLEN-1:0] pc2,
	input logic                valid2
);

	// a stalled edge leaves the pipe register untouched
	stallHoldsPc: assert property (@(posedge clk) disable iff (!nrst)
		stall |=> $stable(pc2) && $stable(valid2))
		else $error("pc2 or valid2 moved across a stalled edge");

	// nothing valid while held in reset
	resetClearsValid: assert property (@(posedge clk)
		!nrst |-> !valid2)
		else $error("valid2 high during reset");

	// trap vector reaches pc2 once the next edge is not stalled
	// pc2 takes the vector before any return can move fetch
	trapReachesPc2: assert property (@(posedge clk) disable iff (!nrst)
		trapTake ##1 !stall |=> pc2 == `FE_TRAP_VEC)
		else $error("accepted trap did not show the trap vector on pc2");

endmodule

//--- frontendStage.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module frontendStage import fe_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                stall,       // freeze whole front end
	input  pcSel_e              pcSel,
	input  logic [`FE_XLEN-1:0] target,
	input  logic                excReq,      // strobe
	input  logic                excRet,      // strobe
	input  logic                dbgWe,       // program load
	input  logic [`FE_XLEN-1:0] dbgAddr,
	input  logic [`FE_XLEN-1:0] dbgData,
	output logic [`FE_XLEN-1:0] pc2,
	output logic [`FE_XLEN-1:0] instr2,      // to decode
	output logic                misaligned2,
	output logic                valid2,
	output logic [`FE_XLEN-1:0] savedPc      // pc replaced by last trap
);

	logic [`FE_XLEN-1:0] fetchPc;
	logic                fetchMisaligned;
	logic                trapTake;
	logic                retTake;
	logic                readEn;

	assign readEn = ~stall; // imem and pipe reg advance together

	excCtrl excCtrl_i (
		.clk      (clk),
		.nrst     (nrst),
		.excReq   (excReq),
		.excRet   (excRet),
		.fetchPc  (fetchPc),
		.trapTake (trapTake),
		.retTake  (retTake),
		.savedPc  (savedPc)
	);

	pcGen pcGen_i (
		.clk             (clk),
		.nrst            (nrst),
		.stall           (stall),
		.pcSel           (pcSel),
		.target          (target),
		.trapTake        (trapTake),
		.retTake         (retTake),
		.savedPc         (savedPc),
		.fetchPc         (fetchPc),
		.fetchMisaligned (fetchMisaligned)
	);

	instrMem instrMem_i (
		.clk     (clk),
		.readEn  (readEn),
		.addr    (fetchPc),
		.instr   (instr2), // registered, already pipe 2
		.dbgWe   (dbgWe),
		.dbgAddr (dbgAddr),
		.dbgData (dbgData)
	);

	fetchReg fetchReg_i (
		.clk             (clk),
		.nrst            (nrst),
		.hold            (~readEn),
		.fetchPc         (fetchPc),
		.fetchMisaligned (fetchMisaligned),
		.pc2             (pc2),
		.misaligned2     (misaligned2),
		.valid2          (valid2)
	);

endmodule

//--- fetchReg.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module fetchReg
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                hold,            // stall freezes all
	input  logic [`FE_XLEN-1:0] fetchPc,         // address imem reads now
	input  logic                fetchMisaligned, // flag for that address
	output logic [`FE_XLEN-1:0] pc2,             // lines up with instr2
	output logic                misaligned2,
	output logic                valid2           // first real fetch done
);

	// control bits cleared on reset
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			misaligned2 <= 1'b0;
			valid2      <= 1'b0;
		end
		else if (!hold)
		begin
			misaligned2 <= fetchMisaligned;
			valid2      <= 1'b1; // sticky once fetch started
		end
	end

	// pc payload
	// same edge as the imem read so pc2 matches instr2
	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			pc2 <= fetchPc;
		end
	end

endmodule

//--- instrMem.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module instrMem
(
	input  logic                clk,
	input  logic                readEn,  // low holds instr
	input  logic [`FE_XLEN-1:0] addr,    // byte address
	output logic [`FE_XLEN-1:0] instr,   // registered read data
	input  logic                dbgWe,   // debug load strobe
	input  logic [`FE_XLEN-1:0] dbgAddr, // byte address of word to load
	input  logic [`FE_XLEN-1:0] dbgData  // word to load
);

	logic [`FE_XLEN-1:0] mem [`FE_MEM_WORDS];

	logic [`FE_MEM_AW-1:0] rdIdx;
	logic [`FE_MEM_AW-1:0] wrIdx;

	// word index without the byte offset bits
	assign rdIdx = addr[`FE_MEM_AW+1:2];
	assign wrIdx = dbgAddr[`FE_MEM_AW+1:2];

	// debug write port takes one word per strobe
	always_ff @(posedge clk)
	begin
		if (dbgWe)
		begin
			mem[wrIdx] <= dbgData;
		end
	end

	// sync read
	// same-cycle write to this word gives old data
	always_ff @(posedge clk)
	begin
		if (readEn)
		begin
			instr <= mem[rdIdx];
		end
	end

endmodule

//--- excCtrl.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module excCtrl import fe_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                excReq,   // exception request strobe
	input  logic                excRet,   // return from handler strobe
	input  logic [`FE_XLEN-1:0] fetchPc,  // current fetch address
	output logic                trapTake, // redirect to trap vector
	output logic                retTake,  // redirect to savedPc
	output logic [`FE_XLEN-1:0] savedPc   // pc replaced by last trap
);

	excState_e excState;

	// a strobe outside the matching state is dropped
	assign trapTake = excReq && (excState == EXC_IDLE);
	assign retTake  = excRet && (excState == EXC_ACTIVE);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			excState <= EXC_IDLE;
			savedPc  <= '0;
		end
		else if (trapTake)
		begin
			excState <= EXC_ACTIVE;
			savedPc  <= fetchPc; // interrupted fetch address
		end
		else if (retTake)
		begin
			excState <= EXC_IDLE; // savedPc kept for visibility
		end
	end

endmodule

//--- pcGen.sv
`timescale 1ns/1ps
`include "fe_defines.svh"

module pcGen import fe_pkg::*;
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                stall,           // freeze, level
	input  pcSel_e              pcSel,           // next pc choice
	input  logic [`FE_XLEN-1:0] target,          // branch / jump address
	input  logic                trapTake,        // accepted exception, from excCtrl
	input  logic                retTake,         // accepted return, from excCtrl
	input  logic [`FE_XLEN-1:0] savedPc,         // resume address
	output logic [`FE_XLEN-1:0] fetchPc,         // address presented to imem
	output logic                fetchMisaligned  // travels with fetchPc
);

	logic [`FE_XLEN-1:0] nextPc;
	logic                nextMisaligned;
	logic [`FE_XLEN-1:0] seqPc;

	assign seqPc = fetchPc + `FE_XLEN'd4; // byte addressed so 4 per word

	// next address select
	// trap and return win over stall so an exception is never lost
	always_comb
	begin
		nextPc = fetchPc; // default hold
		if (trapTake)
		begin
			nextPc = `FE_TRAP_VEC; // redirect to handler
		end
		else if (retTake)
		begin
			nextPc = savedPc; // back to interrupted fetch
		end
		else if (stall)
		begin
			nextPc = fetchPc; // frozen
		end
		else
		begin
			unique case (pcSel)
				PC_SEQ:
				begin
					nextPc = seqPc;
				end
				PC_RESET:
				begin
					nextPc = `FE_RESET_VEC;
				end
				PC_TARGET:
				begin
					nextPc = target; // may be unaligned
				end
				PC_HOLD:
				begin
					nextPc = fetchPc;
				end
				default:
				begin
					nextPc = seqPc;
				end
			endcase
		end
	end

	// only target or savedPc can carry low bits here
	assign nextMisaligned = |nextPc[1:0];

	// fetch address register with the flag registered alongside
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			fetchPc         <= `FE_RESET_VEC;
			fetchMisaligned <= 1'b0;
		end
		else
		begin
			fetchPc         <= nextPc;
			fetchMisaligned <= nextMisaligned; // recomputes same value on hold
		end
	end

endmodule

//--- fe_pkg.sv
package fe_pkg;

	// next fetch address choice
	typedef enum logic [1:0]
	{
		PC_SEQ    = 2'b00, // pc + 4
		PC_RESET  = 2'b01, // back to reset vector
		PC_TARGET = 2'b10, // branch / jump target
		PC_HOLD   = 2'b11  // refetch same address
	} pcSel_e;

	// exception pending flag as a two state machine
	typedef enum logic
	{
		EXC_IDLE   = 1'b0, // no trap in progress
		EXC_ACTIVE = 1'b1  // in handler, waiting for return
	} excState_e;

endpackage

//--- fe_defines.svh
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// datapath and address width
`define FE_XLEN 32

// instruction memory geometry
`define FE_MEM_WORDS 64
`define FE_MEM_AW 6 // word index bits, addr[7:2]

// first fetch after reset
`define FE_RESET_VEC 32'h0000_0000

// exception handler entry
`define FE_TRAP_VEC 32'h0000_0080

`endif
